// File: common/l2_pkg.sv
`default_nettype none

package l2_pkg;

    // cache geometry
    localparam int l2_ways        = 4;
    localparam int l2_sets        = 4;
    localparam int l2_line_words  = 4;
    localparam int l2_line_bits   = 128;
    localparam int l2_offset_bits = 2;
    localparam int l2_index_bits  = 2;
    localparam int l2_tag_bits    = 26;

    // derived address fields, byte offset sits below the word offset
    localparam int l2_way_bits  = $clog2(l2_ways);
    localparam int l2_index_lsb = l2_offset_bits + 2;
    localparam int l2_tag_lsb   = l2_index_lsb + l2_index_bits;

    // who the held request came from
    typedef enum logic [1:0] {
        src_none  = 2'd0,
        src_ic_rd = 2'd1,
        src_dc_rd = 2'd2,
        src_dc_wr = 2'd3
    } l2_src_e;

    typedef enum logic [2:0] {
        st_idle        = 3'd0,
        st_lookup      = 3'd1,
        st_writeback   = 3'd2,
        st_refill_req  = 3'd3,
        st_refill_wait = 3'd4,
        st_respond     = 3'd5
    } l2_state_e;

endpackage

`default_nettype wire

// File: common/l2_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface l2_req_if
    import l2_pkg::*;
();
    logic        valid;
    l2_src_e     src;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    // completion pulse from the control stage
    logic        done;

    modport producer (
        output valid, src, addr, wdata, wstrb,
        input  done
    );

    modport consumer (
        input  valid, src, addr, wdata, wstrb,
        output done
    );

endinterface

`default_nettype wire

// File: logic/l2_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module l2_arbiter
    import l2_pkg::*;
(
    input  wire          clk,
    input  wire          rstn,
    input  wire          ic_req,
    input  wire  [31:0]  ic_addr,
    input  wire          dc_req,
    input  wire          dc_wr,
    input  wire  [31:0]  dc_addr,
    input  wire  [31:0]  dc_wdata,
    input  wire  [3:0]   dc_wstrb,
    output logic         ic_addr_ok,
    output logic         dc_addr_ok,
    l2_req_if.producer   req
);
    logic accept;

    // data side wins, nothing is taken while a request is held
    assign dc_addr_ok = dc_req && !req.valid;
    assign ic_addr_ok = ic_req && !dc_req && !req.valid;
    assign accept     = dc_addr_ok || ic_addr_ok;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req.valid <= 1'b0;
            req.src   <= src_none;
        end else if (accept) begin
            req.valid <= 1'b1;
            if (dc_req)
                req.src <= dc_wr ? src_dc_wr : src_dc_rd;
            else
                req.src <= src_ic_rd;
        end else if (req.done) begin
            req.valid <= 1'b0;
            req.src   <= src_none;
        end
    end

    // request fields
    always_ff @(posedge clk) begin
        if (accept) begin
            req.addr  <= dc_req ? dc_addr : ic_addr;
            req.wdata <= dc_wdata;
            req.wstrb <= dc_req ? dc_wstrb : 4'b0000;
        end
    end

    // held request stays put until done
    assert property (@(posedge clk) disable iff (!rstn)
        (req.valid && !req.done) |=> (req.valid && $stable(req.addr)));

endmodule

`default_nettype wire

// File: lookup/l2_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module l2_tag_array
    import l2_pkg::*;
(
    input  wire                       clk,
    input  wire                       rstn,
    input  wire  [l2_index_bits-1:0]  index,
    input  wire  [l2_tag_bits-1:0]    tag,
    input  wire  [l2_ways-1:0]        fill_we,
    input  wire  [l2_tag_bits-1:0]    fill_tag,
    input  wire  [l2_ways-1:0]        dirty_set,
    input  wire  [l2_ways-1:0]        dirty_clr,
    input  wire  [l2_way_bits-1:0]    victim_way,
    output logic [l2_ways-1:0]        hit,
    output logic [l2_ways-1:0]        set_valid,
    output logic                      victim_valid,
    output logic                      victim_dirty,
    output logic [l2_tag_bits-1:0]    victim_tag
);
    logic [l2_tag_bits-1:0] tags  [l2_sets][l2_ways];
    logic [l2_ways-1:0]     valid [l2_sets];
    logic [l2_ways-1:0]     dirty [l2_sets];

    // compare against every way of the set
    always_comb begin
        for (int w = 0; w < l2_ways; w++) begin
            hit[w] = valid[index][w] && (tags[index][w] == tag);
        end
    end

    assign set_valid    = valid[index];
    assign victim_valid = valid[index][victim_way];
    assign victim_dirty = dirty[index][victim_way];
    assign victim_tag   = tags[index][victim_way];

    always_ff @(posedge clk) begin
        for (int w = 0; w < l2_ways; w++) begin
            if (fill_we[w])
                tags[index][w] <= fill_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < l2_sets; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
        end else begin
            valid[index] <= valid[index] | fill_we;
            // set wins, a refill for a write leaves the line dirty
            dirty[index] <= (dirty[index] & ~dirty_clr) | dirty_set;
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) $onehot0(hit));

endmodule

`default_nettype wire

// File: lookup/l2_plru.sv
`timescale 1ns/1ps
`default_nettype none

module l2_plru
    import l2_pkg::*;
(
    input  wire                       clk,
    input  wire                       rstn,
    input  wire  [l2_index_bits-1:0]  index,
    input  wire  [l2_ways-1:0]        set_valid,
    input  wire                       touch,
    input  wire  [l2_way_bits-1:0]    touch_way,
    output logic [l2_way_bits-1:0]    victim_way
);
    // bit 0 is the root, bit 1 picks in ways 0/1, bit 2 in ways 2/3
    logic [2:0] tree [l2_sets];
    logic [2:0] cur;

    assign cur = tree[index];

    always_comb begin
        victim_way = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};
        // lowest invalid way overrides the tree
        for (int w = l2_ways - 1; w >= 0; w--) begin
            if (!set_valid[w])
                victim_way = l2_way_bits'(w);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < l2_sets; s++) begin
                tree[s] <= 3'b000;
            end
        end else if (touch) begin
            // point away from the way just used
            tree[index][0] <= ~touch_way[1];
            if (touch_way[1])
                tree[index][2] <= ~touch_way[0];
            else
                tree[index][1] <= ~touch_way[0];
        end
    end

endmodule

`default_nettype wire

// File: logic/l2_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module l2_data_array
    import l2_pkg::*;
(
    input  wire                        clk,
    input  wire  [l2_index_bits-1:0]   index,
    input  wire  [l2_way_bits-1:0]     way,
    input  wire                        line_we,
    input  wire  [l2_line_bits-1:0]    line_in,
    input  wire                        word_we,
    input  wire  [l2_offset_bits-1:0]  word_offset,
    input  wire  [31:0]                word_in,
    input  wire  [3:0]                 wstrb,
    output logic [l2_line_bits-1:0]    line_out
);
    localparam int word_bits = l2_line_bits / l2_line_words;

    logic [l2_line_bits-1:0] lines [l2_sets][l2_ways];
    logic [l2_line_bits-1:0] wr_line;

    assign line_out = lines[index][way];

    // refill line first, then the strobed word laid over it
    always_comb begin
        wr_line = line_we ? line_in : lines[index][way];
        if (word_we) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b])
                    wr_line[word_offset * word_bits + b * 8 +: 8] = word_in[b * 8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_we || word_we)
            lines[index][way] <= wr_line;
    end

endmodule

`default_nettype wire

// File: logic/l2_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module l2_ctrl
    import l2_pkg::*;
(
    input  wire                       clk,
    input  wire                       rstn,
    l2_req_if.consumer                req,
    input  wire  [l2_ways-1:0]        hit,
    input  wire                       victim_valid,
    input  wire                       victim_dirty,
    input  wire  [l2_tag_bits-1:0]    victim_tag,
    input  wire  [l2_way_bits-1:0]    victim_way,
    input  wire  [l2_line_bits-1:0]   line_out,
    output logic [l2_index_bits-1:0]  index,
    output logic [l2_way_bits-1:0]    way,
    output logic [l2_ways-1:0]        fill_we,
    output logic [l2_tag_bits-1:0]    fill_tag,
    output logic [l2_ways-1:0]        dirty_set,
    output logic [l2_ways-1:0]        dirty_clr,
    output logic                      touch,
    output logic [l2_way_bits-1:0]    touch_way,
    output logic                      line_we,
    output logic [l2_line_bits-1:0]   line_in,
    output logic                      word_we,
    output logic                      ic_data_ok,
    output logic                      dc_data_ok,
    output logic [l2_line_bits-1:0]   ic_rdata,
    output logic [l2_line_bits-1:0]   dc_rdata,
    output logic                      mem_req_r,
    output logic [31:0]               mem_addr_r,
    input  wire                       mem_addr_ok_r,
    input  wire                       mem_data_ok,
    input  wire  [l2_line_bits-1:0]   mem_rdata,
    output logic                      mem_req_w,
    output logic [31:0]               mem_addr_w,
    input  wire                       mem_addr_ok_w,
    output logic [l2_line_bits-1:0]   mem_wdata
);
    l2_state_e              state;
    l2_state_e              cur_state;
    l2_state_e              next_state;
    logic [l2_way_bits-1:0] way_q;
    logic [l2_way_bits-1:0] hit_way;
    logic [l2_ways-1:0]     way_oh;
    logic                   is_write;
    logic                   is_ic;
    logic                   lookup_hit;
    logic                   refill;

    // a fresh request is looked up in its first valid cycle
    assign cur_state  = (state == st_idle && req.valid) ? st_lookup : state;
    assign is_write   = (req.src == src_dc_wr);
    assign is_ic      = (req.src == src_ic_rd);
    assign lookup_hit = (cur_state == st_lookup) && (hit != '0);
    assign refill     = (cur_state == st_refill_wait) && mem_data_ok;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < l2_ways; w++) begin
            if (hit[w])
                hit_way = l2_way_bits'(w);
        end
    end

    always_comb begin
        next_state = cur_state;
        case (cur_state)
            st_lookup: begin
                if (hit != '0)
                    next_state = st_respond;
                else if (victim_valid && victim_dirty)
                    next_state = st_writeback;
                else
                    next_state = st_refill_req;
            end
            st_writeback: begin
                if (mem_addr_ok_w)
                    next_state = st_refill_req;
            end
            st_refill_req: begin
                if (mem_addr_ok_r)
                    next_state = st_refill_wait;
            end
            st_refill_wait: begin
                if (mem_data_ok)
                    next_state = st_respond;
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn)
            state <= st_idle;
        else
            state <= next_state;
    end

    // way used for the rest of the request
    always_ff @(posedge clk) begin
        if (cur_state == st_lookup)
            way_q <= (hit != '0) ? hit_way : victim_way;
    end

    assign way    = (cur_state == st_lookup) ? hit_way : way_q;
    assign way_oh = l2_ways'(1) << way_q;
    assign index  = req.addr[l2_tag_lsb-1:l2_index_lsb];

    // array updates
    assign fill_we   = refill ? way_oh : '0;
    assign fill_tag  = req.addr[31:l2_tag_lsb];
    assign dirty_set = (lookup_hit && is_write) ? hit :
                       (refill && is_write) ? way_oh : '0;
    assign dirty_clr = (refill && !is_write) ? way_oh : '0;
    assign touch     = lookup_hit || refill;
    assign touch_way = way;
    assign line_we   = refill;
    assign line_in   = mem_rdata;
    assign word_we   = is_write && (lookup_hit || refill);

    // response
    assign req.done   = (cur_state == st_respond);
    assign ic_data_ok = req.done && is_ic;
    assign dc_data_ok = req.done && !is_ic;
    assign ic_rdata   = is_ic ? line_out : '0;
    assign dc_rdata   = is_ic ? '0 : line_out;

    // memory side, both addresses line aligned
    assign mem_req_w  = (cur_state == st_writeback);
    assign mem_addr_w = {victim_tag, index, {l2_index_lsb{1'b0}}};
    assign mem_wdata  = line_out;
    assign mem_req_r  = (cur_state == st_refill_req);
    assign mem_addr_r = {req.addr[31:l2_index_lsb], {l2_index_lsb{1'b0}}};

    // write-back held with a steady address until the bridge takes it
    assert property (@(posedge clk) disable iff (!rstn)
        (mem_req_w && !mem_addr_ok_w) |=> (mem_req_w && $stable(mem_addr_w)));

    assert property (@(posedge clk) disable iff (!rstn)
        (ic_data_ok || dc_data_ok) |-> req.valid);

endmodule

`default_nettype wire

// File: logic/l2_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module l2_cache_top
    import l2_pkg::*;
(
    input  wire                      clk,
    input  wire                      rstn,
    // instruction cache
    input  wire                      ic_req,
    input  wire [31:0]               ic_addr,
    output wire                      ic_addr_ok,
    output wire                      ic_data_ok,
    output wire [l2_line_bits-1:0]   ic_rdata,
    // data cache
    input  wire                      dc_req,
    input  wire                      dc_wr,
    input  wire [31:0]               dc_addr,
    input  wire [31:0]               dc_wdata,
    input  wire [3:0]                dc_wstrb,
    output wire                      dc_addr_ok,
    output wire                      dc_data_ok,
    output wire [l2_line_bits-1:0]   dc_rdata,
    // memory bridge
    output wire                      mem_req_r,
    output wire [31:0]               mem_addr_r,
    input  wire                      mem_addr_ok_r,
    input  wire                      mem_data_ok,
    input  wire [l2_line_bits-1:0]   mem_rdata,
    output wire                      mem_req_w,
    output wire [31:0]               mem_addr_w,
    output wire [l2_line_bits-1:0]   mem_wdata,
    input  wire                      mem_addr_ok_w
);
    l2_req_if req_bus ();

    wire [l2_ways-1:0]       hit;
    wire [l2_ways-1:0]       set_valid;
    wire                     victim_valid;
    wire                     victim_dirty;
    wire [l2_tag_bits-1:0]   victim_tag;
    wire [l2_way_bits-1:0]   victim_way;
    wire [l2_line_bits-1:0]  line_out;
    wire [l2_index_bits-1:0] index;
    wire [l2_way_bits-1:0]   way;
    wire [l2_ways-1:0]       fill_we;
    wire [l2_tag_bits-1:0]   fill_tag;
    wire [l2_ways-1:0]       dirty_set;
    wire [l2_ways-1:0]       dirty_clr;
    wire                     touch;
    wire [l2_way_bits-1:0]   touch_way;
    wire                     line_we;
    wire [l2_line_bits-1:0]  line_in;
    wire                     word_we;

    l2_arbiter u_arbiter (
        .clk        (clk),
        .rstn       (rstn),
        .ic_req     (ic_req),
        .ic_addr    (ic_addr),
        .dc_req     (dc_req),
        .dc_wr      (dc_wr),
        .dc_addr    (dc_addr),
        .dc_wdata   (dc_wdata),
        .dc_wstrb   (dc_wstrb),
        .ic_addr_ok (ic_addr_ok),
        .dc_addr_ok (dc_addr_ok),
        .req        (req_bus.producer)
    );

    l2_tag_array u_tag_array (
        .clk          (clk),
        .rstn         (rstn),
        .index        (index),
        .tag          (req_bus.addr[31:l2_tag_lsb]),
        .fill_we      (fill_we),
        .fill_tag     (fill_tag),
        .dirty_set    (dirty_set),
        .dirty_clr    (dirty_clr),
        .victim_way   (victim_way),
        .hit          (hit),
        .set_valid    (set_valid),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    l2_plru u_plru (
        .clk        (clk),
        .rstn       (rstn),
        .index      (index),
        .set_valid  (set_valid),
        .touch      (touch),
        .touch_way  (touch_way),
        .victim_way (victim_way)
    );

    l2_data_array u_data_array (
        .clk         (clk),
        .index       (index),
        .way         (way),
        .line_we     (line_we),
        .line_in     (line_in),
        .word_we     (word_we),
        .word_offset (req_bus.addr[l2_index_lsb-1:2]),
        .word_in     (req_bus.wdata),
        .wstrb       (req_bus.wstrb),
        .line_out    (line_out)
    );

    l2_ctrl u_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .req           (req_bus.consumer),
        .hit           (hit),
        .victim_valid  (victim_valid),
        .victim_dirty  (victim_dirty),
        .victim_tag    (victim_tag),
        .victim_way    (victim_way),
        .line_out      (line_out),
        .index         (index),
        .way           (way),
        .fill_we       (fill_we),
        .fill_tag      (fill_tag),
        .dirty_set     (dirty_set),
        .dirty_clr     (dirty_clr),
        .touch         (touch),
        .touch_way     (touch_way),
        .line_we       (line_we),
        .line_in       (line_in),
        .word_we       (word_we),
        .ic_data_ok    (ic_data_ok),
        .dc_data_ok    (dc_data_ok),
        .ic_rdata      (ic_rdata),
        .dc_rdata      (dc_rdata),
        .mem_req_r     (mem_req_r),
        .mem_addr_r    (mem_addr_r),
        .mem_addr_ok_r (mem_addr_ok_r),
        .mem_data_ok   (mem_data_ok),
        .mem_rdata     (mem_rdata),
        .mem_req_w     (mem_req_w),
        .mem_addr_w    (mem_addr_w),
        .mem_addr_ok_w (mem_addr_ok_w),
        .mem_wdata     (mem_wdata)
    );

endmodule

`default_nettype wire

// File: tests/l2_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module l2_mem_model
    import l2_pkg::*;
(
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      mem_req_r,
    input  wire  [31:0]              mem_addr_r,
    output logic                     mem_addr_ok_r,
    output logic                     mem_data_ok,
    output logic [l2_line_bits-1:0]  mem_rdata,
    input  wire                      mem_req_w,
    input  wire  [31:0]              mem_addr_w,
    input  wire  [l2_line_bits-1:0]  mem_wdata,
    output logic                     mem_addr_ok_w
);
    // shadow memory covers byte addresses 0 to 0x3ff
    logic [31:0] words [256];
    int unsigned lcg_state;
    logic [31:0] line_addr;

    function automatic logic [31:0] pattern_word(input logic [31:0] waddr);
        return waddr ^ {waddr[15:0], waddr[31:16]} ^ 32'h1357_9bdf;
    endfunction

    // one generator step gives 1 to 6 cycles
    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return 1 + int'((lcg_state >> 16) % 6);
    endfunction

    initial begin
        lcg_state     = 81096;
        mem_addr_ok_r = 1'b0;
        mem_addr_ok_w = 1'b0;
        mem_data_ok   = 1'b0;
        mem_rdata     = '0;
        for (int i = 0; i < 256; i++) begin
            words[i] = pattern_word(32'(i));
        end
    end

    always begin
        @(posedge clk);
        if (rstn && mem_req_w) begin
            repeat (next_delay()) @(posedge clk);
            mem_addr_ok_w <= 1'b1;
            @(posedge clk);
            mem_addr_ok_w <= 1'b0;
            // line taken on the accepting edge
            for (int k = 0; k < l2_line_words; k++) begin
                words[mem_addr_w[9:2] + k] = mem_wdata[32 * k +: 32];
            end
            $display("mem: write-back of line %h, data %h", mem_addr_w, mem_wdata);
        end else if (rstn && mem_req_r) begin
            repeat (next_delay()) @(posedge clk);
            mem_addr_ok_r <= 1'b1;
            @(posedge clk);
            mem_addr_ok_r <= 1'b0;
            line_addr = mem_addr_r;
            repeat (next_delay()) @(posedge clk);
            for (int k = 0; k < l2_line_words; k++) begin
                mem_rdata[32 * k +: 32] <= words[line_addr[9:2] + k];
            end
            mem_data_ok <= 1'b1;
            @(posedge clk);
            mem_data_ok <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_l2_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l2_cache
    import l2_pkg::*;
();
    localparam int timeout_cycles = 100;

    logic                    clk;
    logic                    rstn;
    logic                    ic_req;
    logic [31:0]             ic_addr;
    wire                     ic_addr_ok;
    wire                     ic_data_ok;
    wire  [l2_line_bits-1:0] ic_rdata;
    logic                    dc_req;
    logic                    dc_wr;
    logic [31:0]             dc_addr;
    logic [31:0]             dc_wdata;
    logic [3:0]              dc_wstrb;
    wire                     dc_addr_ok;
    wire                     dc_data_ok;
    wire  [l2_line_bits-1:0] dc_rdata;
    wire                     mem_req_r;
    wire  [31:0]             mem_addr_r;
    wire                     mem_addr_ok_r;
    wire                     mem_data_ok;
    wire  [l2_line_bits-1:0] mem_rdata;
    wire                     mem_req_w;
    wire  [31:0]             mem_addr_w;
    wire  [l2_line_bits-1:0] mem_wdata;
    wire                     mem_addr_ok_w;

    // stimulus columns
    int          src_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] wdata_q[$];
    logic [3:0]  strb_q[$];
    int          pair_q[$];
    int          kind_q[$];

    // reference cache state and the memory image reads should return
    logic [l2_tag_bits-1:0] model_tag [l2_sets][l2_ways];
    logic [l2_ways-1:0]     model_valid [l2_sets];
    logic [l2_ways-1:0]     model_dirty [l2_sets];
    logic [2:0]             model_tree [l2_sets];
    logic [31:0]            gold [256];

    int mismatches;
    int failures;
    logic aborted;
    int i;

    always #20 clk = ~clk;

    l2_cache_top i_dut (.*);

    l2_mem_model u_mem (
        .clk           (clk),
        .rstn          (rstn),
        .mem_req_r     (mem_req_r),
        .mem_addr_r    (mem_addr_r),
        .mem_addr_ok_r (mem_addr_ok_r),
        .mem_data_ok   (mem_data_ok),
        .mem_rdata     (mem_rdata),
        .mem_req_w     (mem_req_w),
        .mem_addr_w    (mem_addr_w),
        .mem_wdata     (mem_wdata),
        .mem_addr_ok_w (mem_addr_ok_w)
    );

    function automatic logic [31:0] pattern_word(input logic [31:0] waddr);
        return waddr ^ {waddr[15:0], waddr[31:16]} ^ 32'h1357_9bdf;
    endfunction

    function automatic logic [l2_line_bits-1:0] gold_line(input logic [31:0] addr);
        logic [l2_line_bits-1:0] line;
        for (int k = 0; k < l2_line_words; k++) begin
            line[32 * k +: 32] = gold[{addr[9:4], k[1:0]}];
        end
        return line;
    endfunction

    // lowest invalid way first, else follow the tree
    function automatic int pick_victim(input int idx);
        int v;
        v = model_tree[idx][0] ? 2 + int'(model_tree[idx][2]) : int'(model_tree[idx][1]);
        for (int w = l2_ways - 1; w >= 0; w--) begin
            if (!model_valid[idx][w])
                v = w;
        end
        return v;
    endfunction

    task automatic note_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        mismatches++;
        $display("ERR %0t ns: %s = %h, expected %h", $time, name, got, exp);
    endtask

    task automatic note_failure(input string what);
        failures++;
        $display("FAILURE %0t ns: %s", $time, what);
    endtask

    task automatic load_stim();
        int    fd;
        int    n;
        int    src;
        int    pair;
        int    kind;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        string line;
        fd = $fopen("tests/l2_stim.txt", "r");
        if (fd == 0) begin
            note_failure("cannot open tests/l2_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %h %h %h %d %d", src, addr, wdata, strb, pair, kind);
                    if (n == 6) begin
                        src_q.push_back(src);
                        addr_q.push_back(addr);
                        wdata_q.push_back(wdata);
                        strb_q.push_back(strb);
                        pair_q.push_back(pair);
                        kind_q.push_back(kind);
                    end else begin
                        note_failure("malformed line in the stimulus file");
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_idle_outputs();
        assert (!ic_addr_ok && !dc_addr_ok && !ic_data_ok && !dc_data_ok &&
                !mem_req_r && !mem_req_w)
        else note_failure("a handshake output is high before the first request");
    endtask

    task automatic apply_write(input logic [31:0] addr, input logic [31:0] wd,
                               input logic [3:0] st);
        for (int b = 0; b < 4; b++) begin
            if (st[b])
                gold[addr[9:2]][8 * b +: 8] = wd[8 * b +: 8];
        end
    endtask

    // updates the reference cache, returns 0 hit, 1 clean miss, 2 dirty miss
    task automatic predict(input int src, input logic [31:0] addr,
                           output int kind, output logic [31:0] wb_addr);
        int idx;
        int way;
        idx     = int'(addr[5:4]);
        way     = -1;
        kind    = 0;
        wb_addr = '0;
        for (int w = 0; w < l2_ways; w++) begin
            if (model_valid[idx][w] && model_tag[idx][w] == addr[31:6])
                way = w;
        end
        if (way < 0) begin
            way  = pick_victim(idx);
            kind = 1;
            if (model_valid[idx][way] && model_dirty[idx][way]) begin
                kind    = 2;
                wb_addr = {model_tag[idx][way], addr[5:4], 4'b0000};
            end
            model_tag[idx][way]   = addr[31:6];
            model_valid[idx][way] = 1'b1;
            model_dirty[idx][way] = 1'b0;
        end
        if (src == 2)
            model_dirty[idx][way] = 1'b1;
        // tree bits point away from the way just used
        model_tree[idx][0] = (way < 2);
        if (way < 2)
            model_tree[idx][1] = (way == 0);
        else
            model_tree[idx][2] = (way == 2);
    endtask

    task automatic drive_req(input int n);
        if (src_q[n] == 0) begin
            ic_req  <= 1'b1;
            ic_addr <= addr_q[n];
        end else begin
            dc_req   <= 1'b1;
            dc_wr    <= (src_q[n] == 2);
            dc_addr  <= addr_q[n];
            dc_wdata <= wdata_q[n];
            dc_wstrb <= strb_q[n];
        end
    endtask

    task automatic complete_req(input int n);
        int          cnt;
        int          pred_kind;
        int          seen_kind;
        logic        is_ic;
        logic        ok;
        logic        seen_w;
        logic        seen_r;
        logic [31:0] exp_wb;
        logic [31:0] got_wb;
        logic [127:0] exp_wb_data;
        logic [127:0] wb_data;
        logic [127:0] rdata;
        is_ic  = (src_q[n] == 0);
        seen_w = 1'b0;
        seen_r = 1'b0;
        got_wb = '0;
        wb_data = '0;
        rdata  = '0;
        predict(src_q[n], addr_q[n], pred_kind, exp_wb);
        exp_wb_data = gold_line(exp_wb);
        assert (pred_kind == kind_q[n])
        else note_failure($sformatf("stimulus kind for %h disagrees with the cache model",
                                    addr_q[n]));
        cnt = 0;
        ok  = 1'b0;
        while (!ok && cnt < timeout_cycles) begin
            @(negedge clk);
            cnt++;
            ok = is_ic ? ic_addr_ok : dc_addr_ok;
            assert (!(is_ic ? dc_addr_ok : ic_addr_ok))
            else note_failure("addr_ok given to the other requester");
        end
        if (!ok) begin
            note_failure("timeout waiting for addr_ok");
            aborted = 1'b1;
        end else begin
            @(posedge clk);
            if (is_ic)
                ic_req <= 1'b0;
            else
                dc_req <= 1'b0;
            cnt = 0;
            ok  = 1'b0;
            while (!ok && cnt < timeout_cycles) begin
                @(negedge clk);
                cnt++;
                if (mem_req_w && !seen_w) begin
                    seen_w  = 1'b1;
                    got_wb  = mem_addr_w;
                    wb_data = mem_wdata;
                    assert (!seen_r) else note_failure("mem_req_r came before mem_req_w");
                end
                if (mem_req_r && !seen_r) begin
                    seen_r = 1'b1;
                    assert (mem_addr_r == {addr_q[n][31:4], 4'b0000})
                    else note_mismatch("mem_addr_r", mem_addr_r, {addr_q[n][31:4], 4'b0000});
                end
                assert (!(is_ic ? dc_addr_ok : ic_addr_ok))
                else note_failure("addr_ok given while a request is held");
                ok    = is_ic ? ic_data_ok : dc_data_ok;
                rdata = is_ic ? ic_rdata : dc_rdata;
            end
            if (!ok) begin
                note_failure("timeout waiting for data_ok");
                aborted = 1'b1;
            end else begin
                seen_kind = seen_w ? 2 : (seen_r ? 1 : 0);
                assert (seen_kind == kind_q[n])
                else note_mismatch("access kind", seen_kind, kind_q[n]);
                if (kind_q[n] == 0) begin
                    assert (cnt == 2) else note_mismatch("data_ok latency", cnt, 2);
                end
                if (seen_w) begin
                    assert (got_wb == exp_wb) else note_mismatch("mem_addr_w", got_wb, exp_wb);
                    assert (wb_data == exp_wb_data)
                    else note_mismatch("mem_wdata", wb_data, exp_wb_data);
                end
                if (src_q[n] == 2) begin
                    apply_write(addr_q[n], wdata_q[n], strb_q[n]);
                end else begin
                    assert (rdata == gold_line(addr_q[n]))
                    else note_mismatch(is_ic ? "ic_rdata" : "dc_rdata", rdata,
                                       gold_line(addr_q[n]));
                end
            end
        end
    endtask

    initial begin
        clk      = 1'b0;
        rstn     = 1'b0;
        ic_req   = 1'b0;
        ic_addr  = '0;
        dc_req   = 1'b0;
        dc_wr    = 1'b0;
        dc_addr  = '0;
        dc_wdata = '0;
        dc_wstrb = '0;
        mismatches = 0;
        failures   = 0;
        aborted    = 1'b0;
        for (int s = 0; s < l2_sets; s++) begin
            model_valid[s] = '0;
            model_dirty[s] = '0;
            model_tree[s]  = 3'b000;
        end
        for (int w = 0; w < 256; w++) begin
            gold[w] = pattern_word(32'(w));
        end
        load_stim();
        if (src_q.size() == 0)
            note_failure("no requests in the stimulus file");

        // 4 cycles of reset, outputs must stay low through the first idle cycles
        @(posedge clk);
        repeat (3) begin
            @(negedge clk);
            check_idle_outputs();
            @(posedge clk);
        end
        rstn <= 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_idle_outputs();
        end

        i = 0;
        while (i < src_q.size() && !aborted) begin
            @(posedge clk);
            drive_req(i);
            if (pair_q[i] != 0 && i + 1 < src_q.size()) begin
                // both requesters raise req in the same cycle
                drive_req(i + 1);
                complete_req(i);
                if (!aborted)
                    complete_req(i + 1);
                i += 2;
            end else begin
                complete_req(i);
                i += 1;
            end
        end

        $display("errors: %0d value mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/l2_stim.txt
# src 0 ic read, 1 dc read, 2 dc write; pair 1 issues the next line in the same cycle
# kind 0 hit, 1 clean miss, 2 dirty miss; columns: src addr wdata strb pair kind
0 00000000 00000000 0 0 1
0 00000004 00000000 0 0 0
2 00000008 a1b2c3d4 5 0 0
1 00000000 00000000 0 0 0
2 0000004c 11223344 c 0 1
1 00000040 00000000 0 0 0
0 00000080 00000000 0 0 1
0 000000c0 00000000 0 0 1
1 00000100 00000000 0 0 2
0 00000000 00000000 0 0 1
1 00000080 00000000 0 0 2
2 00000014 55667788 f 1 1
0 000000c0 00000000 0 0 0
1 00000010 00000000 0 1 0
0 00000020 00000000 0 0 1
0 000000c4 00000000 0 0 0
1 00000104 00000000 0 0 0
1 00000048 00000000 0 0 1

// File: flist.f
common/l2_pkg.sv
common/l2_req_if.sv
logic/l2_arbiter.sv
lookup/l2_tag_array.sv
lookup/l2_plru.sv
logic/l2_data_array.sv
logic/l2_ctrl.sv
logic/l2_cache_top.sv
tests/l2_mem_model.sv
tests/tb_l2_cache.sv
